//--- src/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Threads per warp
`define LSU_NUM_THREADS 2

// Outstanding load slots and slot index width
`define LSU_QUEUE_SIZE 4
`define LSU_TAG_BITS 2

// Warp id and register index widths
`define LSU_NW_BITS 2
`define LSU_NR_BITS 5

`endif

//--- src/lsu_pkg.sv
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    // Bit 3 set for stores, bit 2 for unsigned loads, bits 1:0 give the size
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]             wid;
        logic [31:0]                         pc;
        logic [`LSU_NR_BITS-1:0]             rd;
        logic                                wb;
        lsu_op_e                             op;
        logic [`LSU_NUM_THREADS-1:0]         tmask;
        logic [`LSU_NUM_THREADS-1:0][31:0]   base_addr;
        logic [11:0]                         offset;
        logic [`LSU_NUM_THREADS-1:0][31:0]   store_data;
    } lsu_req_t;

    typedef struct packed {
        logic [`LSU_NUM_THREADS-1:0]         valid;
        logic [`LSU_NUM_THREADS-1:0]         rw;
        logic [`LSU_NUM_THREADS-1:0][29:0]   addr;
        logic [`LSU_NUM_THREADS-1:0][3:0]    byteen;
        logic [`LSU_NUM_THREADS-1:0][31:0]   data;
        logic [`LSU_TAG_BITS-1:0]            tag;
    } mem_req_t;

    typedef struct packed {
        logic [`LSU_NUM_THREADS-1:0]         valid;
        logic [`LSU_NUM_THREADS-1:0][31:0]   data;
        logic [`LSU_TAG_BITS-1:0]            tag;
    } mem_rsp_t;

    typedef struct packed {
        logic                                valid;
        logic [`LSU_NW_BITS-1:0]             wid;
        logic [31:0]                         pc;
        logic [`LSU_NR_BITS-1:0]             rd;
        logic                                wb;
        logic [`LSU_NUM_THREADS-1:0]         tmask;
        logic [`LSU_NUM_THREADS-1:0][31:0]   data;
        logic                                eop;
    } commit_t;

    // Held per slot until the last response of a load
    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]             wid;
        logic [31:0]                         pc;
        logic [`LSU_NR_BITS-1:0]             rd;
        lsu_op_e                             op;
        logic [`LSU_NUM_THREADS-1:0][1:0]    offset;
    } load_meta_t;

endpackage

`default_nettype wire

//--- src/lsu_dispatch.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_dispatch (
    input  wire                              clk,
    input  wire                              reset,
    input  lsu_pkg::lsu_req_t                req,
    input  wire                              req_valid,
    output logic                             req_ready,
    output lsu_pkg::lsu_req_t                cur,
    output logic                             cur_valid,
    output logic [`LSU_TAG_BITS-1:0]         tag,
    output logic [`LSU_NUM_THREADS-1:0]      mem_req_valid,
    input  wire  [`LSU_NUM_THREADS-1:0]      mem_req_ready,
    output logic                             alloc,
    output lsu_pkg::load_meta_t              alloc_meta,
    output logic [`LSU_NUM_THREADS-1:0]      alloc_tmask,
    input  wire  [`LSU_TAG_BITS-1:0]         slot_free,
    input  wire                              full,
    output lsu_pkg::commit_t                 st_commit
);
    import lsu_pkg::*;

    lsu_req_t                         req_full;
    lsu_req_t                         cur_q;
    logic                             valid_q;
    logic [`LSU_NUM_THREADS-1:0]      sent_mask;
    logic [`LSU_NUM_THREADS-1:0]      fire;
    logic [`LSU_TAG_BITS-1:0]         tag_hold;
    logic                             is_store;
    logic                             first;
    logic                             all_sent;

    // Full address per thread with a sign-extended offset
    always_comb begin
        req_full = req;
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            req_full.base_addr[i] = req.base_addr[i] + {{20{req.offset[11]}}, req.offset};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (req_ready) begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready) begin
            cur_q <= req_full;
        end
    end

    // --------------------
    // Thread send tracking
    // --------------------
    assign is_store = cur_q.op[3];
    assign first    = (sent_mask == '0);

    // A load waits for a slot only before its first thread goes out
    assign mem_req_valid = {`LSU_NUM_THREADS{valid_q && (is_store || !full || !first)}}
                         & cur_q.tmask & ~sent_mask;

    assign fire     = mem_req_valid & mem_req_ready;
    assign all_sent = &(fire | sent_mask | ~cur_q.tmask);
    assign req_ready = !valid_q || all_sent;

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_mask <= '0;
        end else if (all_sent) begin
            sent_mask <= '0;
        end else begin
            sent_mask <= sent_mask | fire;
        end
    end

    // Slot index is fixed on the first fire of a load
    assign alloc = !is_store && first && (|fire);

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_hold <= slot_free;
        end
    end

    assign tag = first ? slot_free : tag_hold;

    always_comb begin
        alloc_meta.wid = cur_q.wid;
        alloc_meta.pc  = cur_q.pc;
        alloc_meta.rd  = cur_q.rd;
        alloc_meta.op  = cur_q.op;
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            alloc_meta.offset[i] = cur_q.base_addr[i][1:0];
        end
    end

    assign alloc_tmask = cur_q.tmask;
    assign cur         = cur_q;
    assign cur_valid   = valid_q;

    // Store retires when its last thread leaves
    always_comb begin
        st_commit       = '0;
        st_commit.valid = valid_q && is_store && all_sent;
        st_commit.wid   = cur_q.wid;
        st_commit.pc    = cur_q.pc;
        st_commit.tmask = cur_q.tmask;
        st_commit.eop   = 1'b1;
    end

    a_no_early_ready: assert property (@(posedge clk) disable iff (reset)
        valid_q && |(cur_q.tmask & ~sent_mask & ~mem_req_ready) |-> !req_ready);

endmodule

`default_nettype wire

//--- src/lsu_store_format.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_store_format (
    input  lsu_pkg::lsu_req_t                cur,
    input  wire  [`LSU_NUM_THREADS-1:0]      cur_valid_mask,
    input  wire  [`LSU_TAG_BITS-1:0]         tag,
    output lsu_pkg::mem_req_t                mem_req
);
    import lsu_pkg::*;

    logic [`LSU_NUM_THREADS-1:0][1:0] byte_off;

    always_comb begin
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            byte_off[i] = cur.base_addr[i][1:0];
        end
    end

    always_comb begin
        mem_req.tag = tag;
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            mem_req.valid[i] = cur_valid_mask[i];
            mem_req.rw[i]    = cur.op[3];
            mem_req.addr[i]  = cur.base_addr[i][31:2];

            // Loads read the whole word
            case (cur.op)
                SB:      mem_req.byteen[i] = 4'b0001 << byte_off[i];
                SH:      mem_req.byteen[i] = byte_off[i][1] ? 4'b1100 : 4'b0011;
                default: mem_req.byteen[i] = 4'b1111;
            endcase

            // Move the store bytes up to their lane
            mem_req.data[i] = cur.store_data[i] << {byte_off[i], 3'b000};
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_tag_buffer.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_tag_buffer (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              alloc,
    input  lsu_pkg::load_meta_t              alloc_meta,
    input  wire  [`LSU_NUM_THREADS-1:0]      alloc_tmask,
    output logic [`LSU_TAG_BITS-1:0]         slot_free,
    output logic                             full,
    input  wire  [`LSU_NUM_THREADS-1:0]      rsp_fire,
    input  wire  [`LSU_TAG_BITS-1:0]         rsp_tag,
    output lsu_pkg::load_meta_t              rsp_meta,
    output logic                             rsp_last
);
    import lsu_pkg::*;

    logic [`LSU_QUEUE_SIZE-1:0]                            used;
    load_meta_t                                            meta_mem [`LSU_QUEUE_SIZE];
    logic [`LSU_QUEUE_SIZE-1:0][`LSU_NUM_THREADS-1:0]      rem_mask;
    logic [`LSU_NUM_THREADS-1:0]                           rem_next;
    logic                                                  rsp_any;

    // Lowest free slot wins
    always_comb begin
        slot_free = '0;
        for (int i = `LSU_QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!used[i]) begin
                slot_free = `LSU_TAG_BITS'(i);
            end
        end
    end

    assign full = &used;

    // --------------------
    // Response side
    // --------------------
    assign rsp_any  = |rsp_fire;
    assign rem_next = rem_mask[rsp_tag] & ~rsp_fire;
    assign rsp_last = (rem_next == '0);
    assign rsp_meta = meta_mem[rsp_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else begin
            if (alloc) begin
                used[slot_free] <= 1'b1;
            end
            if (rsp_any && rsp_last) begin
                used[rsp_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            meta_mem[slot_free] <= alloc_meta;
            rem_mask[slot_free] <= alloc_tmask;
        end
        if (rsp_any) begin
            rem_mask[rsp_tag] <= rem_next;
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !full);

    // Responses only come back for loads that were issued
    a_rsp_slot_used: assert property (@(posedge clk) disable iff (reset)
        rsp_any |-> used[rsp_tag]);

endmodule

`default_nettype wire

//--- src/lsu_load_format.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_load_format (
    input  wire                              clk,
    input  wire                              reset,
    input  lsu_pkg::mem_rsp_t                mem_rsp,
    output logic                             mem_rsp_ready,
    output logic [`LSU_NUM_THREADS-1:0]      rsp_fire,
    input  lsu_pkg::load_meta_t              rsp_meta,
    input  wire                              rsp_last,
    output lsu_pkg::commit_t                 ld_commit,
    input  wire                              ld_commit_ready
);
    import lsu_pkg::*;

    logic [`LSU_NUM_THREADS-1:0][31:0] shifted;
    logic [`LSU_NUM_THREADS-1:0][31:0] ext_data;
    commit_t                           commit_q;
    logic                              stall;

    assign stall         = commit_q.valid && !ld_commit_ready;
    assign mem_rsp_ready = !stall;
    assign rsp_fire      = mem_rsp.valid & {`LSU_NUM_THREADS{mem_rsp_ready}};

    // Bring the addressed byte or half down to bit 0
    always_comb begin
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            shifted[i] = mem_rsp.data[i] >> {rsp_meta.offset[i], 3'b000};
        end
    end

    always_comb begin
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            case (rsp_meta.op)
                LB:      ext_data[i] = {{24{shifted[i][7]}}, shifted[i][7:0]};
                LH:      ext_data[i] = {{16{shifted[i][15]}}, shifted[i][15:0]};
                LBU:     ext_data[i] = {24'b0, shifted[i][7:0]};
                LHU:     ext_data[i] = {16'b0, shifted[i][15:0]};
                default: ext_data[i] = shifted[i];
            endcase
        end
    end

    // --------------------
    // Commit register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_q <= '0;
        end else if (!stall) begin
            commit_q.valid <= |mem_rsp.valid;
            commit_q.wid   <= rsp_meta.wid;
            commit_q.pc    <= rsp_meta.pc;
            commit_q.rd    <= rsp_meta.rd;
            commit_q.wb    <= 1'b1;
            commit_q.tmask <= mem_rsp.valid;
            commit_q.data  <= ext_data;
            commit_q.eop   <= rsp_last;
        end
    end

    assign ld_commit = commit_q;

    a_commit_hold: assert property (@(posedge clk) disable iff (reset)
        ld_commit.valid && !ld_commit_ready |=> $stable(ld_commit));

endmodule

`default_nettype wire

//--- src/lsu_unit.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_unit (
    input  wire                              clk,
    input  wire                              reset,
    input  lsu_pkg::lsu_req_t                req,
    input  wire                              req_valid,
    output logic                             req_ready,
    output lsu_pkg::mem_req_t                mem_req,
    input  wire  [`LSU_NUM_THREADS-1:0]      mem_req_ready,
    input  lsu_pkg::mem_rsp_t                mem_rsp,
    output logic                             mem_rsp_ready,
    output lsu_pkg::commit_t                 ld_commit,
    input  wire                              ld_commit_ready,
    output lsu_pkg::commit_t                 st_commit
);
    import lsu_pkg::*;

    lsu_req_t                         cur;
    logic                             cur_valid;
    logic [`LSU_TAG_BITS-1:0]         tag;
    logic [`LSU_NUM_THREADS-1:0]      mem_req_valid;
    logic                             alloc;
    load_meta_t                       alloc_meta;
    logic [`LSU_NUM_THREADS-1:0]      alloc_tmask;
    logic [`LSU_TAG_BITS-1:0]         slot_free;
    logic                             full;
    logic [`LSU_NUM_THREADS-1:0]      rsp_fire;
    load_meta_t                       rsp_meta;
    logic                             rsp_last;

    lsu_dispatch u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .cur           (cur),
        .cur_valid     (cur_valid),
        .tag           (tag),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .alloc         (alloc),
        .alloc_meta    (alloc_meta),
        .alloc_tmask   (alloc_tmask),
        .slot_free     (slot_free),
        .full          (full),
        .st_commit     (st_commit)
    );

    lsu_store_format u_store_format (
        .cur            (cur),
        .cur_valid_mask (mem_req_valid),
        .tag            (tag),
        .mem_req        (mem_req)
    );

    lsu_tag_buffer u_tag_buffer (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .alloc_meta  (alloc_meta),
        .alloc_tmask (alloc_tmask),
        .slot_free   (slot_free),
        .full        (full),
        .rsp_fire    (rsp_fire),
        .rsp_tag     (mem_rsp.tag),
        .rsp_meta    (rsp_meta),
        .rsp_last    (rsp_last)
    );

    lsu_load_format u_load_format (
        .clk             (clk),
        .reset           (reset),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready),
        .rsp_fire        (rsp_fire),
        .rsp_meta        (rsp_meta),
        .rsp_last        (rsp_last),
        .ld_commit       (ld_commit),
        .ld_commit_ready (ld_commit_ready)
    );

    // Addresses stay put on the cache port while an instruction is part sent
    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        cur_valid && !req_ready |=> cur_valid && $stable(mem_req.addr));

endmodule

`default_nettype wire

//--- verification/lsu_checker.sv
`default_nettype none

`include "lsu_config.svh"

module lsu_checker (
    input  wire                              clk,
    input  wire                              reset,
    input  lsu_pkg::lsu_req_t                req,
    input  wire                              req_valid,
    input  wire                              req_ready,
    input  lsu_pkg::mem_req_t                mem_req,
    input  wire  [`LSU_NUM_THREADS-1:0]      mem_req_ready,
    input  wire                              mem_rsp_ready,
    input  lsu_pkg::commit_t                 ld_commit,
    input  wire                              ld_commit_ready,
    input  lsu_pkg::commit_t                 st_commit,
    output int                               errors,
    output int                               open_ops
);
    import lsu_pkg::*;

    localparam int NT      = `LSU_NUM_THREADS;
    localparam int MAX_OPS = 512;

    logic [31:0]               shadow [64];
    lsu_req_t                  cur;
    logic [NT-1:0][31:0]       cur_addr;
    logic [NT-1:0]             cur_sent;
    logic [NT-1:0]             fired;
    lsu_req_t                  log_req  [MAX_OPS];
    logic [NT-1:0]             got_mask [MAX_OPS];
    logic [NT-1:0][31:0]       exp_val  [MAX_OPS];
    logic                      pending  [MAX_OPS];
    int                        loads_in_flight;

    function automatic logic [31:0] fill_word(input int a);
        logic [7:0] b;
        b = {a[5:0], 2'b00};
        return 32'ha5c3_96e1 ^ {4{b}};
    endfunction

    function automatic logic [3:0] store_mask(input lsu_op_e op, input logic [1:0] off);
        case (op)
            SB:      return 4'b0001 << off;
            SH:      return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    // Pick the addressed byte or half, then extend
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] off,
                                               input lsu_op_e op);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{off, 3'b000} +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic check_request(input int i);
        logic [1:0] off;
        off = cur_addr[i][1:0];
        if (!cur.tmask[i] || cur_sent[i]) begin
            report_failure($sformatf("Thread %0d of pc 0x%h fired outside its mask or twice",
                                     i, cur.pc));
        end
        compare_value("mem_req.addr", {2'b00, mem_req.addr[i]}, {2'b00, cur_addr[i][31:2]});
        compare_value("mem_req.rw", 32'(mem_req.rw[i]), 32'(cur.op[3]));
        compare_value("mem_req.byteen", {28'h0, mem_req.byteen[i]},
                      {28'h0, store_mask(cur.op, off)});
        if (cur.op[3]) begin
            compare_value("mem_req.data", mem_req.data[i], cur.store_data[i] << {off, 3'b000});
        end
    endtask

    task automatic write_shadow(input int i);
        logic [3:0]  be;
        logic [31:0] data;
        logic [5:0]  w;
        be   = store_mask(cur.op, cur_addr[i][1:0]);
        data = cur.store_data[i] << {cur_addr[i][1:0], 3'b000};
        w    = cur_addr[i][7:2];
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                shadow[w][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    initial begin
        errors          = 0;
        open_ops        = 0;
        loads_in_flight = 0;
        cur             = '0;
        cur_addr        = '0;
        cur_sent        = '0;
        for (int a = 0; a < 64; a++) begin
            shadow[a] = fill_word(a);
        end
        for (int n = 0; n < MAX_OPS; n++) begin
            pending[n] = 1'b0;
        end
    end

    // Ports settle by the falling edge; what is seen here fires at the next rise
    always @(negedge clk) begin
        int idx;
        int slot_limit;
        if (!reset) begin
            // --------------------
            // Cache requests
            // --------------------
            fired = mem_req.valid & mem_req_ready;
            // A load whose last beat waits on ld_commit has already freed its slot
            slot_limit = `LSU_QUEUE_SIZE + int'(ld_commit.valid && ld_commit.eop);
            if (|fired && !cur.op[3] && cur_sent == '0) begin
                loads_in_flight++;
                if (loads_in_flight > slot_limit) begin
                    report_failure($sformatf("%0d loads in flight at once", loads_in_flight));
                end
            end
            for (int i = 0; i < NT; i++) begin
                if (fired[i]) begin
                    check_request(i);
                end
            end
            cur_sent = cur_sent | fired;

            if (st_commit.valid) begin
                idx = int'(st_commit.pc[10:2]);
                if (!pending[idx] || !log_req[idx].op[3]) begin
                    report_failure($sformatf("Store commit for pc 0x%h with no open store",
                                             st_commit.pc));
                end else begin
                    compare_value("st_commit.wid", 32'(st_commit.wid), 32'(log_req[idx].wid));
                    compare_value("st_commit.tmask", 32'(st_commit.tmask),
                                  32'(log_req[idx].tmask));
                    compare_value("st_commit.rd", 32'(st_commit.rd), 32'h0);
                    compare_value("st_commit.eop", 32'(st_commit.eop), 32'h1);
                    pending[idx] = 1'b0;
                    open_ops--;
                end
            end

            // --------------------
            // Load commits
            // --------------------
            compare_value("mem_rsp_ready", 32'(mem_rsp_ready),
                          32'(!(ld_commit.valid && !ld_commit_ready)));
            if (ld_commit.valid && ld_commit_ready) begin
                idx = int'(ld_commit.pc[10:2]);
                if (!pending[idx] || log_req[idx].op[3]) begin
                    report_failure($sformatf("Load commit for pc 0x%h with no open load",
                                             ld_commit.pc));
                end else if (|(ld_commit.tmask & ~(log_req[idx].tmask & ~got_mask[idx]))) begin
                    report_failure($sformatf("Load pc 0x%h commits threads %b again or unasked",
                                             ld_commit.pc, ld_commit.tmask));
                end else begin
                    for (int i = 0; i < NT; i++) begin
                        if (ld_commit.tmask[i]) begin
                            compare_value("ld_commit.data", ld_commit.data[i], exp_val[idx][i]);
                        end
                    end
                    compare_value("ld_commit.rd", 32'(ld_commit.rd), 32'(log_req[idx].rd));
                    compare_value("ld_commit.wid", 32'(ld_commit.wid), 32'(log_req[idx].wid));
                    compare_value("ld_commit.wb", 32'(ld_commit.wb), 32'h1);
                    got_mask[idx] = got_mask[idx] | ld_commit.tmask;
                    compare_value("ld_commit.eop", 32'(ld_commit.eop),
                                  32'(got_mask[idx] == log_req[idx].tmask));
                    if (got_mask[idx] == log_req[idx].tmask) begin
                        pending[idx] = 1'b0;
                        open_ops--;
                        loads_in_flight--;
                    end
                end
            end

            // New instruction enters the unit
            if (req_valid && req_ready) begin
                cur      = req;
                cur_sent = '0;
                idx      = int'(req.pc[10:2]);
                log_req[idx]  = req;
                got_mask[idx] = '0;
                pending[idx]  = 1'b1;
                open_ops++;
                for (int i = 0; i < NT; i++) begin
                    cur_addr[i] = req.base_addr[i] + {{20{req.offset[11]}}, req.offset};
                    if (req.tmask[i] && req.op[3]) begin
                        write_shadow(i);
                    end else if (req.tmask[i]) begin
                        exp_val[idx][i] = load_value(shadow[cur_addr[i][7:2]],
                                                     cur_addr[i][1:0], req.op);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_lsu_unit.sv
`default_nettype none

`include "lsu_config.svh"

module tb_lsu_unit;
    import lsu_pkg::*;

    localparam int NUM_REQ   = 300;
    localparam int NT        = `LSU_NUM_THREADS;
    localparam int WAIT_MAX  = 2000;
    localparam int DRIVE_DLY = 10;

    logic                        clk;
    logic                        reset;
    lsu_req_t                    req;
    logic                        req_valid;
    logic                        req_ready;
    mem_req_t                    mem_req;
    logic [NT-1:0]               mem_req_ready;
    mem_rsp_t                    mem_rsp;
    logic                        mem_rsp_ready;
    commit_t                     ld_commit;
    logic                        ld_commit_ready;
    commit_t                     st_commit;

    int                          seed;
    int                          errors;
    int                          open_ops;
    int                          cycle;
    int                          lat_max;
    bit                          timed_out;
    logic                        took_req;
    logic [31:0]                 mem [64];
    lsu_op_e                     ops [8];

    // Load reads waiting to be returned
    int                          q_thread [$];
    logic [`LSU_TAG_BITS-1:0]    q_tag    [$];
    logic [31:0]                 q_data   [$];
    int                          q_due    [$];

    lsu_unit dut (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready),
        .ld_commit       (ld_commit),
        .ld_commit_ready (ld_commit_ready),
        .st_commit       (st_commit)
    );

    lsu_checker u_checker (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_ready   (mem_rsp_ready),
        .ld_commit       (ld_commit),
        .ld_commit_ready (ld_commit_ready),
        .st_commit       (st_commit),
        .errors          (errors),
        .open_ops        (open_ops)
    );

    always #50 clk = ~clk;

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        logic [7:0] b;
        b = {a[5:0], 2'b00};
        return 32'ha5c3_96e1 ^ {4{b}};
    endfunction

    // --------------------
    // Memory model advanced one clock per call
    // --------------------
    task automatic step_cycle();
        logic [NT-1:0] fired;
        logic          rsp_taken;
        mem_req_t      snap;
        int            k;
        @(negedge clk);
        snap      = mem_req;
        fired     = mem_req.valid & mem_req_ready;
        rsp_taken = (|mem_rsp.valid) && mem_rsp_ready;
        took_req  = req_valid && req_ready;
        @(posedge clk);
        #DRIVE_DLY;
        cycle++;
        for (int i = 0; i < NT; i++) begin
            if (fired[i] && snap.rw[i]) begin
                for (int b = 0; b < 4; b++) begin
                    if (snap.byteen[i][b]) begin
                        mem[snap.addr[i][5:0]][b*8 +: 8] = snap.data[i][b*8 +: 8];
                    end
                end
            end else if (fired[i]) begin
                q_thread.push_back(i);
                q_tag.push_back(snap.tag);
                q_data.push_back(mem[snap.addr[i][5:0]]);
                q_due.push_back(cycle + 1 + rand_below(lat_max));
            end
        end
        if (rsp_taken) begin
            mem_rsp.valid = '0;
        end
        // Any due entry may go next, so responses return out of order
        if (mem_rsp.valid == '0 && q_due.size() > 0) begin
            k = rand_below(q_due.size());
            if (q_due[k] <= cycle) begin
                mem_rsp = '0;
                mem_rsp.valid[q_thread[k]] = 1'b1;
                mem_rsp.data[q_thread[k]]  = q_data[k];
                mem_rsp.tag                = q_tag[k];
                q_thread.delete(k);
                q_tag.delete(k);
                q_data.delete(k);
                q_due.delete(k);
            end
        end
        for (int i = 0; i < NT; i++) begin
            mem_req_ready[i] = (rand_below(4) != 0);
        end
        ld_commit_ready = (rand_below(4) != 0);
    endtask

    task automatic build_request(input int n);
        logic [31:0] r;
        int          w;
        int          step;
        req       = '0;
        req.op    = ops[rand_below(8)];
        req.pc    = 32'(n * 4);
        r         = $random(seed);
        req.wid   = r[`LSU_NW_BITS-1:0];
        req.rd    = r[8 +: `LSU_NR_BITS];
        req.wb    = !req.op[3];
        while (req.tmask == '0) begin
            r         = $random(seed);
            req.tmask = r[NT-1:0];
        end
        // Threads land on different words
        w    = rand_below(64);
        step = 1 + rand_below(64 / NT - 1);
        for (int i = 0; i < NT; i++) begin
            req.base_addr[i]  = 32'h0000_1000 + 32'(((w + i * step) % 64) * 4);
            req.store_data[i] = $random(seed);
        end
        case (req.op[1:0])
            2'b00:   req.offset = 12'(rand_below(4));
            2'b01:   req.offset = 12'(rand_below(2) * 2);
            default: req.offset = 12'h0;
        endcase
    endtask

    task automatic send_request();
        int waited;
        waited    = 0;
        took_req  = 1'b0;
        req_valid = 1'b1;
        while (!took_req && waited < WAIT_MAX) begin
            step_cycle();
            waited++;
        end
        if (!took_req) begin
            $display("Timeout: request with pc 0x%h was never accepted", req.pc);
            timed_out = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((open_ops != 0 || q_due.size() != 0 || |mem_rsp.valid)
               && waited < WAIT_MAX * 4) begin
            step_cycle();
            waited++;
        end
        if (open_ops != 0) begin
            $display("Timeout: %0d instructions never committed", open_ops);
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_run();
        $display("Closing: %0d errors, %0d timeouts", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        seed            = 775;
        clk             = 1'b0;
        reset           = 1'b1;
        req             = '0;
        req_valid       = 1'b0;
        mem_req_ready   = '0;
        mem_rsp         = '0;
        ld_commit_ready = 1'b0;
        cycle           = 0;
        lat_max         = 6;
        timed_out       = 1'b0;
        took_req        = 1'b0;
        ops = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
        for (int a = 0; a < 64; a++) begin
            mem[a] = fill_word(a);
        end
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        for (int n = 0; n < NUM_REQ && !timed_out; n++) begin
            // Slow responses so loads pile up in the tag buffer
            if (n == 200) begin
                lat_max = 24;
            end
            build_request(n);
            send_request();
        end
        req_valid = 1'b0;
        if (!timed_out) begin
            drain();
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/lsu_pkg.sv
src/lsu_dispatch.sv
src/lsu_store_format.sv
src/lsu_tag_buffer.sv
src/lsu_load_format.sv
src/lsu_unit.sv
verification/lsu_checker.sv
verification/tb_lsu_unit.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_lsu_unit -Mdir obj_dir
	./obj_dir/Vtb_lsu_unit | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
